//--- design/led_matrix_pkg.sv
//////////////////////////////
// one 64x32 panel, two 16-row halves, no chaining
// colour depth equals the number of bit planes
//////////////////////////////
package led_matrix_pkg;

    // panel geometry
    localparam int PIXEL_WIDTH = 64;
    localparam int PIXEL_HEIGHT = 32;
    // upper and lower halves are shifted out together
    localparam int PIXEL_HALFHEIGHT = PIXEL_HEIGHT / 2;

    // bits per channel, one bit plane per bit
    localparam int BRIGHTNESS_LEVELS = 4;

    // address widths
    localparam int COLUMN_ADDRESS_BITS = $clog2(PIXEL_WIDTH);
    localparam int ROW_ADDRESS_BITS = $clog2(PIXEL_HALFHEIGHT);
    // write side sees the full panel height
    localparam int FRAME_ROW_BITS = $clog2(PIXEL_HEIGHT);

    // enable length of plane 0 in clk_in cycles
    // plane n is lit for OE_BASE_CYCLES << n
    localparam int OE_BASE_CYCLES = 8;
    // next line load may begin once this many enable cycles remain
    localparam int OE_OVERLAP_CYCLES = 4;
    // wide enough for the top plane weight
    localparam int OE_TIMER_BITS =
        $clog2((OE_BASE_CYCLES << (BRIGHTNESS_LEVELS - 1)) + 1);

    // one pixel as stored in the frame buffer
    // each channel is a binary brightness value, msb brightest
    typedef struct packed {
        logic [BRIGHTNESS_LEVELS-1:0] red;
        logic [BRIGHTNESS_LEVELS-1:0] green;
        logic [BRIGHTNESS_LEVELS-1:0] blue;
    } pixel_t;

endpackage

//--- design/timeout.sv
//////////////////////////////
// counter stops at zero, start reloads at any time
// value 0 never raises running
//////////////////////////////
`timescale 1ns/10ps

module timeout #(
    parameter int COUNTER_WIDTH = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // load on start, otherwise count down and hold at zero
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - COUNTER_WIDTH'(1);
        end
    end

    // high for exactly value cycles after the start edge
    assign running = (counter != '0);

    // running only rises from a load in the previous cycle
    assert property (@(posedge clk_in) disable iff (reset)
        running |-> ($past(start) || $past(running)))
    else
        $error("timeout running without a start");

endmodule

//--- design/brightness_timeout.sv
//////////////////////////////
// mask must be one-hot at the latch
// enable length is OE_BASE_CYCLES << plane index
//////////////////////////////
`timescale 1ns/10ps

module brightness_timeout (
    input  logic                                        clk_in,
    input  logic                                        reset,
    input  logic                                        row_latch,
    input  logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0] brightness_mask_active,
    output logic                                        output_enable,
    output logic                                        exceeded_overlap_time
);

    import led_matrix_pkg::*;

    // enable length for the plane just latched
    logic [OE_TIMER_BITS-1:0] plane_weight;
    // enable cycles still to go
    logic [OE_TIMER_BITS-1:0] remaining;

    // one-hot mask to binary weight
    // zero mask gives zero weight, so the enable stays off
    always_comb begin
        plane_weight = '0;
        for (int i = 0; i < BRIGHTNESS_LEVELS; i++) begin
            if (brightness_mask_active[i]) begin
                plane_weight = OE_TIMER_BITS'(OE_BASE_CYCLES << i);
            end
        end
    end

    // latch pulse starts the enable window
    timeout #(
        .COUNTER_WIDTH(OE_TIMER_BITS)
    ) i_oe_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (row_latch),
        .value  (plane_weight),
        .counter(remaining),
        .running(output_enable)
    );

    // tail of the window, the next line may start shifting
    assign exceeded_overlap_time =
        output_enable && (remaining <= OE_TIMER_BITS'(OE_OVERLAP_CYCLES));

    // scan side must hand over a single plane at each latch
    assert property (@(posedge clk_in) disable iff (reset)
        row_latch |-> $onehot0(brightness_mask_active))
    else
        $error("active brightness mask not one-hot at row latch");

endmodule

//--- design/matrix_scan.sv
//////////////////////////////
// free running scan, no back-pressure
// latch timing follows the plane weight
//////////////////////////////
`timescale 1ns/10ps

module matrix_scan (
    input  logic                                          clk_in,
    input  logic                                          reset,
    output logic [led_matrix_pkg::COLUMN_ADDRESS_BITS-1:0] column_address,
    output logic [led_matrix_pkg::ROW_ADDRESS_BITS-1:0]    row_address,
    output logic [led_matrix_pkg::ROW_ADDRESS_BITS-1:0]    row_address_active,
    output logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0]   brightness_mask,
    output logic                                          clk_pixel_load,
    output logic                                          clk_pixel,
    output logic                                          row_latch,
    output logic                                          output_enable
);

    import led_matrix_pkg::*;

    // request history, newest in bit 0
    logic [1:0] state;
    logic       state_advance;
    logic       load_start;

    // high for PIXEL_WIDTH cycles per line
    logic clk_pixel_load_en;
    // load enable delayed half a cycle
    logic clk_pixel_en;
    // load enable history on the falling edge
    logic [1:0] row_latch_state;
    // falling edge that opens the latch pulse
    logic       latch_begin;

    // plane currently lit on the panel
    logic [BRIGHTNESS_LEVELS-1:0] brightness_mask_active;
    logic                         exceeded_overlap_time;

    // gated pixel clocks
    assign clk_pixel_load = clk_in && clk_pixel_load_en;
    assign clk_pixel = clk_in && clk_pixel_en;

    // ask for the next line while dark or near the end of the enable
    assign state_advance = !output_enable || exceeded_overlap_time;
    // rising request starts one load
    assign load_start = (state == 2'b01);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00;
        end else begin
            state <= {state[0], state_advance};
        end
    end

    // PIXEL_WIDTH load clocks per line
    timeout #(
        .COUNTER_WIDTH(COLUMN_ADDRESS_BITS + 1)
    ) i_load_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (load_start),
        .value  ((COLUMN_ADDRESS_BITS + 1)'(PIXEL_WIDTH)),
        .counter(),
        .running(clk_pixel_load_en)
    );

    // column runs from the last column down to 0, then holds
    timeout #(
        .COUNTER_WIDTH(COLUMN_ADDRESS_BITS)
    ) i_column_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (load_start),
        .value  (COLUMN_ADDRESS_BITS'(PIXEL_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    // latch is the falling-edge sample after the load enable drops
    assign latch_begin = row_latch_state[0] && !clk_pixel_load_en;
    assign row_latch = (row_latch_state == 2'b10);

    // falling edge side, half a cycle away from the data registers
    always_ff @(negedge clk_in) begin
        if (reset) begin
            clk_pixel_en <= 1'b1;
            row_latch_state <= 2'b00;
            brightness_mask <= {1'b1, {(BRIGHTNESS_LEVELS - 1){1'b0}}};
            brightness_mask_active <= '0;
            row_address <= '0;
            row_address_active <= '0;
        end else begin
            clk_pixel_en <= clk_pixel_load_en;
            row_latch_state <= {row_latch_state[0], clk_pixel_load_en};
            // line just shifted in becomes the lit line
            if (latch_begin) begin
                brightness_mask_active <= brightness_mask;
                row_address_active <= row_address;
                // last plane done, back to the msb on the next row
                if (brightness_mask[0]) begin
                    brightness_mask <= {1'b1, {(BRIGHTNESS_LEVELS - 1){1'b0}}};
                    row_address <= row_address + ROW_ADDRESS_BITS'(1);
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    // weighted enable for the latched plane
    brightness_timeout i_brightness_timeout (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask_active),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap_time)
    );

    // exactly one plane selected at all times
    assert property (@(posedge clk_in) disable iff (reset)
        $onehot(brightness_mask))
    else
        $error("brightness mask not one-hot");

    // no shifting while the panel latches
    assert property (@(posedge clk_in) disable iff (reset)
        row_latch |-> !clk_pixel_load_en)
    else
        $error("row latch overlaps pixel load");

endmodule

//--- design/frame_buffer.sv
//////////////////////////////
// single frame, no double buffering
// one cycle read latency from column_address
//////////////////////////////
`timescale 1ns/10ps

module frame_buffer (
    input  logic                                          clk_in,
    input  logic                                          reset,
    input  logic                                          wr_en,
    input  logic [led_matrix_pkg::FRAME_ROW_BITS-1:0]      wr_row,
    input  logic [led_matrix_pkg::COLUMN_ADDRESS_BITS-1:0] wr_column,
    input  led_matrix_pkg::pixel_t                        wr_pixel,
    input  logic [led_matrix_pkg::COLUMN_ADDRESS_BITS-1:0] column_address,
    input  logic [led_matrix_pkg::ROW_ADDRESS_BITS-1:0]    row_address,
    input  logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0]   brightness_mask,
    output logic [2:0]                                    rgb_top,
    output logic [2:0]                                    rgb_bottom
);

    import led_matrix_pkg::*;

    // one array per half so both read in the same cycle
    pixel_t mem_top [PIXEL_HALFHEIGHT][PIXEL_WIDTH];
    pixel_t mem_bottom [PIXEL_HALFHEIGHT][PIXEL_WIDTH];

    // row within the half, msb of wr_row picks the half
    logic [ROW_ADDRESS_BITS-1:0] wr_half_row;
    logic                        wr_lower_half;

    pixel_t pixel_top;
    pixel_t pixel_bottom;

    // picks the masked bit of each channel
    // result is {red, green, blue}
    function automatic logic [2:0] plane_bits(
        input pixel_t                       pixel,
        input logic [BRIGHTNESS_LEVELS-1:0] mask
    );
        plane_bits = {|(pixel.red & mask), |(pixel.green & mask), |(pixel.blue & mask)};
    endfunction

    assign wr_half_row = wr_row[ROW_ADDRESS_BITS-1:0];
    assign wr_lower_half = wr_row[FRAME_ROW_BITS-1];

    // write port
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_lower_half) begin
                mem_bottom[wr_half_row][wr_column] <= wr_pixel;
            end else begin
                mem_top[wr_half_row][wr_column] <= wr_pixel;
            end
        end
    end

    // same row in both halves
    assign pixel_top = mem_top[row_address][column_address];
    assign pixel_bottom = mem_bottom[row_address][column_address];

    // registered so the bits sit still at the pixel clock
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_top <= 3'b000;
            rgb_bottom <= 3'b000;
        end else begin
            rgb_top <= plane_bits(pixel_top, brightness_mask);
            rgb_bottom <= plane_bits(pixel_bottom, brightness_mask);
        end
    end

endmodule

//--- design/hub75_driver.sv
//////////////////////////////
// single panel, writes allowed while scanning
//////////////////////////////
`timescale 1ns/10ps

module hub75_driver (
    input  logic                                          clk_in,
    input  logic                                          reset,
    // frame write side
    input  logic                                          wr_en,
    input  logic [led_matrix_pkg::FRAME_ROW_BITS-1:0]      wr_row,
    input  logic [led_matrix_pkg::COLUMN_ADDRESS_BITS-1:0] wr_column,
    input  led_matrix_pkg::pixel_t                        wr_pixel,
    // panel pins
    output logic                                          clk_pixel_load,
    output logic                                          clk_pixel,
    output logic                                          row_latch,
    output logic                                          output_enable,
    output logic [led_matrix_pkg::ROW_ADDRESS_BITS-1:0]    row_address,
    output logic [led_matrix_pkg::ROW_ADDRESS_BITS-1:0]    row_address_active,
    output logic [led_matrix_pkg::COLUMN_ADDRESS_BITS-1:0] column_address,
    output logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0]   brightness_mask,
    output logic [2:0]                                    rgb_top,
    output logic [2:0]                                    rgb_bottom
);

    // timing, addressing and enable
    matrix_scan i_matrix_scan (
        .clk_in            (clk_in),
        .reset             (reset),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .brightness_mask   (brightness_mask),
        .clk_pixel_load    (clk_pixel_load),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable)
    );

    // pixel store, read by the scan addresses
    frame_buffer i_frame_buffer (
        .clk_in         (clk_in),
        .reset          (reset),
        .wr_en          (wr_en),
        .wr_row         (wr_row),
        .wr_column      (wr_column),
        .wr_pixel       (wr_pixel),
        .column_address (column_address),
        .row_address    (row_address),
        .brightness_mask(brightness_mask),
        .rgb_top        (rgb_top),
        .rgb_bottom     (rgb_bottom)
    );

endmodule

//--- tests/hub75_driver_tb.sv
//////////////////////////////
// directed checks of scan timing, enable weights and pixel data
// all monitoring is done 2 ns after the rising edge of clk_in
//////////////////////////////
`timescale 1ns/10ps

module hub75_driver_tb;

    import led_matrix_pkg::*;

    localparam int DRIVE_DELAY = 2;
    localparam int TOP_PLANE = BRIGHTNESS_LEVELS - 1;
    localparam int FRAME_LINES = PIXEL_HALFHEIGHT * BRIGHTNESS_LEVELS;
    // generous bound on the gap between two latches
    localparam int LATCH_TIMEOUT = 4 * (PIXEL_WIDTH + (OE_BASE_CYCLES << TOP_PLANE));
    // pixel rewritten while scanning, lower half
    localparam int LIVE_ROW = PIXEL_HALFHEIGHT + 5;
    localparam int LIVE_COLUMN = 17;

    logic                           clk_in;
    logic                           reset;
    logic                           wr_en;
    logic [FRAME_ROW_BITS-1:0]      wr_row;
    logic [COLUMN_ADDRESS_BITS-1:0] wr_column;
    pixel_t                         wr_pixel;
    logic                           clk_pixel_load;
    logic                           clk_pixel;
    logic                           row_latch;
    logic                           output_enable;
    logic [ROW_ADDRESS_BITS-1:0]    row_address;
    logic [ROW_ADDRESS_BITS-1:0]    row_address_active;
    logic [COLUMN_ADDRESS_BITS-1:0] column_address;
    logic [BRIGHTNESS_LEVELS-1:0]   brightness_mask;
    logic [2:0]                     rgb_top;
    logic [2:0]                     rgb_bottom;

    // copy of everything written to the frame buffer
    pixel_t model_frame [PIXEL_HEIGHT][PIXEL_WIDTH];
    integer seed;
    int     failures;

    // monitor state
    logic                           monitor_on;
    logic                           pixels_on;
    logic                           line_synced;
    logic                           oe_open;
    logic                           load_prev;
    logic [PIXEL_WIDTH-1:0]         columns_seen;
    logic [COLUMN_ADDRESS_BITS-1:0] prev_column;
    int                             exp_plane;
    int                             exp_row;
    int                             latch_count;
    int                             load_count;
    int                             pixel_count;
    int                             oe_count;
    int                             oe_weight;
    int                             target_hits;

    hub75_driver i_dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .wr_en             (wr_en),
        .wr_row            (wr_row),
        .wr_column         (wr_column),
        .wr_pixel          (wr_pixel),
        .clk_pixel_load    (clk_pixel_load),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .column_address    (column_address),
        .brightness_mask   (brightness_mask),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom)
    );

    // 40 ns clock
    initial begin
        clk_in = 1'b0;
        forever begin
            #20 clk_in = ~clk_in;
        end
    end

    task automatic abort_run();
        failures++;
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, expected);
        abort_run();
    endtask

    task automatic report_failure(string text);
        $display("%0t ns: %s", $time, text);
        abort_run();
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        assert (got === expected) else report_mismatch(name, got, expected);
    endtask

    task automatic expect_true(logic cond, string text);
        assert (cond === 1'b1) else report_failure(text);
    endtask

    // {red, green, blue} bit of one plane
    function automatic logic [2:0] expected_bits(input pixel_t pixel, input int plane);
        return {pixel.red[plane], pixel.green[plane], pixel.blue[plane]};
    endfunction

    // one clock cycle, then all per-cycle checks
    task automatic sample_cycle();
        logic [2:0] exp_top;
        logic [2:0] exp_bottom;
        @(posedge clk_in);
        #DRIVE_DELAY;
        if (monitor_on) begin
            if (row_latch) begin
                expect_true(!oe_open, "previous enable window still open at row latch");
                if (line_synced) begin
                    check_value("clk_pixel_load pulses", 32'(load_count), 32'(PIXEL_WIDTH));
                    check_value("clk_pixel pulses", 32'(pixel_count), 32'(PIXEL_WIDTH));
                    expect_true(&columns_seen, "not every column was shifted out in a line");
                end
                check_value("brightness_mask_active",
                    32'(i_dut.i_matrix_scan.brightness_mask_active), 32'(1 << exp_plane));
                check_value("row_address_active", 32'(row_address_active), 32'(exp_row));
                oe_weight = OE_BASE_CYCLES << exp_plane;
                // lsb plane done, next row from the msb
                if (exp_plane == 0) begin
                    exp_plane = TOP_PLANE;
                    exp_row = (exp_row + 1) % PIXEL_HALFHEIGHT;
                end else begin
                    exp_plane--;
                end
                check_value("brightness_mask", 32'(brightness_mask), 32'(1 << exp_plane));
                check_value("row_address", 32'(row_address), 32'(exp_row));
                oe_open = 1'b1;
                oe_count = 0;
                load_count = 0;
                pixel_count = 0;
                columns_seen = '0;
                latch_count++;
                line_synced = 1'b1;
            end
            // enable window length
            if (output_enable) begin
                expect_true(oe_open, "output_enable high without a row latch");
                oe_count++;
            end else if (oe_open) begin
                check_value("output_enable cycles", 32'(oe_count), 32'(oe_weight));
                oe_open = 1'b0;
            end
            // a new load may only overlap the tail of the enable
            // remaining enable cycles include the current one
            if (clk_pixel_load && !load_prev && output_enable) begin
                expect_true(oe_weight - oe_count + 1 <= OE_OVERLAP_CYCLES,
                    "pixel load started before the enable overlap point");
            end
            if (clk_pixel_load) begin
                load_count++;
            end
            if (clk_pixel) begin
                pixel_count++;
                // prev_column is the column present when clk_pixel rose
                if (line_synced) begin
                    expect_true(!columns_seen[prev_column], "column shifted out twice in a line");
                end
                columns_seen[prev_column] = 1'b1;
                check_value("brightness_mask", 32'(brightness_mask), 32'(1 << exp_plane));
                check_value("row_address", 32'(row_address), 32'(exp_row));
                // a write at this edge is not yet visible on rgb
                if (pixels_on && !wr_en) begin
                    exp_top = expected_bits(model_frame[exp_row][prev_column], exp_plane);
                    exp_bottom = expected_bits(
                        model_frame[exp_row + PIXEL_HALFHEIGHT][prev_column], exp_plane);
                    check_value("rgb_top", 32'(rgb_top), 32'(exp_top));
                    check_value("rgb_bottom", 32'(rgb_bottom), 32'(exp_bottom));
                    if (exp_row == LIVE_ROW - PIXEL_HALFHEIGHT && prev_column == LIVE_COLUMN) begin
                        target_hits++;
                    end
                end
            end
            load_prev = clk_pixel_load;
        end
        prev_column = column_address;
    endtask

    task automatic check_reset_values();
        check_value("output_enable", 32'(output_enable), 32'(0));
        check_value("row_latch", 32'(row_latch), 32'(0));
        check_value("row_address", 32'(row_address), 32'(0));
        check_value("row_address_active", 32'(row_address_active), 32'(0));
        check_value("brightness_mask", 32'(brightness_mask), 32'(1 << TOP_PLANE));
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        for (int i = 0; i < 10; i++) begin
            sample_cycle();
            // falling-edge registers are set from the first negedge on
            if (i > 0) begin
                check_reset_values();
            end
        end
        reset = 1'b0;
        exp_plane = TOP_PLANE;
        exp_row = 0;
        monitor_on = 1'b1;
        sample_cycle();
        check_reset_values();
    endtask

    task automatic wait_for_latches(int count);
        int target;
        int cycles;
        target = latch_count + count;
        cycles = 0;
        while (latch_count < target) begin
            sample_cycle();
            cycles++;
            if (cycles > count * LATCH_TIMEOUT) begin
                report_failure("timeout waiting for row_latch");
            end
        end
    endtask

    // takes effect at the next rising edge
    task automatic write_pixel(int row, int column, pixel_t pixel);
        wr_en = 1'b1;
        wr_row = FRAME_ROW_BITS'(row);
        wr_column = COLUMN_ADDRESS_BITS'(column);
        wr_pixel = pixel;
        model_frame[row][column] = pixel;
        sample_cycle();
        wr_en = 1'b0;
    endtask

    task automatic load_frame();
        logic [31:0] rand_word;
        for (int r = 0; r < PIXEL_HEIGHT; r++) begin
            for (int c = 0; c < PIXEL_WIDTH; c++) begin
                rand_word = $random(seed);
                write_pixel(r, c, rand_word[$bits(pixel_t)-1:0]);
            end
        end
        pixels_on = 1'b1;
    endtask

    // clocks, columns, plane and row order, enable weights
    task automatic check_scan_sequence();
        wait_for_latches(FRAME_LINES + 1);
    endtask

    task automatic check_frame_pixels();
        wait_for_latches(FRAME_LINES);
    endtask

    // inverted pixel differs from the old one in every plane
    task automatic rewrite_live_pixel();
        pixel_t new_pixel;
        int     cycles;
        new_pixel = ~model_frame[LIVE_ROW][LIVE_COLUMN];
        target_hits = 0;
        write_pixel(LIVE_ROW, LIVE_COLUMN, new_pixel);
        cycles = 0;
        while (target_hits < BRIGHTNESS_LEVELS) begin
            sample_cycle();
            cycles++;
            if (cycles > FRAME_LINES * LATCH_TIMEOUT) begin
                report_failure("timeout waiting for the rewritten pixel to be shifted out");
            end
        end
    endtask

    initial begin
        seed = 58;
        failures = 0;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_row = '0;
        wr_column = '0;
        wr_pixel = '0;
        monitor_on = 1'b0;
        pixels_on = 1'b0;
        line_synced = 1'b0;
        oe_open = 1'b0;
        load_prev = 1'b0;
        columns_seen = '0;
        prev_column = '0;
        latch_count = 0;
        load_count = 0;
        pixel_count = 0;
        oe_count = 0;
        oe_weight = 0;
        target_hits = 0;
        apply_reset();
        check_scan_sequence();
        load_frame();
        check_frame_pixels();
        rewrite_live_pixel();
        if (failures == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- filelist.f
design/led_matrix_pkg.sv
design/timeout.sv
design/brightness_timeout.sv
design/matrix_scan.sv
design/frame_buffer.sv
design/hub75_driver.sv
tests/hub75_driver_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
# a $fatal in the run gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module hub75_driver_tb \
    -f filelist.f -o hub75_driver_sim &&
./obj_dir/hub75_driver_sim ||
{ echo "hub75 driver run did not pass"; exit 1; }
